/* sources.f */
+incdir+include
source/cv_ctrl_pkg.sv
source/kbd_keypad_decoder.sv
source/joy_keypad_mapper.sv
source/keypad_encoder.sv
source/ctrl_port_driver.sv
source/cv_ctrl_top.sv
verification/tb_cv_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the controller port testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wall -Wno-fatal \
	--top-module tb_cv_ctrl \
	-f sources.f

# The simulator exit status is judged by the log search below
./obj_dir/Vtb_cv_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* verification/tb_cv_ctrl.sv */
// Testbench for the controller port top level
// Row table of joystick, keyboard and select stimulus with expected pins

`timescale 1ns/10ps
`default_nettype none

`include "cv_ctrl_cfg.svh"

module tb_cv_ctrl;

	import cv_ctrl_pkg::*;

	localparam int WAIT_LIMIT = 16;
	localparam int RUN_LIMIT  = 2000;

	// Select encodings {keypad_sel_n, joy_sel_n}
	localparam port_sel_t SEL_NONE = 2'b11;
	localparam port_sel_t SEL_KP   = 2'b01;
	localparam port_sel_t SEL_JOY  = 2'b10;
	localparam port_sel_t SEL_BOTH = 2'b00;

	localparam port_pins_t PINS_IDLE = 5'b11111;

	typedef struct packed {
		logic [19:0] joy0;
		logic [19:0] joy1;
		logic        swap;
		logic        has_key;
		logic        pressed;
		logic [7:0]  code;
		port_sel_t   sel0;
		port_sel_t   sel1;
		logic [3:0]  wait_cyc;
		port_pins_t  exp0;
		port_pins_t  exp1;
	} row_t;

	logic       clk_sys;
	logic       reset;
	key_event_t key_event;
	logic [31:0] joy0;
	logic [31:0] joy1;
	logic        swap;
	port_sel_t   port_sel  [NUM_PLAYERS];
	port_pins_t  port_pins [NUM_PLAYERS];

	row_t rows [$];

	cv_ctrl_top i_dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.key_event_i (key_event),
		.joy0_i      (joy0),
		.joy1_i      (joy1),
		.swap_i      (swap),
		.port_sel_i  (port_sel),
		.port_pins_o (port_pins)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Overall guard against a stuck run
	initial begin
		repeat (RUN_LIMIT) @(posedge clk_sys);
		$display("Simulation did not finish within %0d cycles", RUN_LIMIT);
		$display("Result: FAILED");
		$fatal(1, "run timeout");
	end

	task automatic add_row(input logic [19:0] j0, input logic [19:0] j1, input logic sw,
			input logic hk, input logic pr, input logic [7:0] cd,
			input port_sel_t s0, input port_sel_t s1, input logic [3:0] wc,
			input port_pins_t e0, input port_pins_t e1);
		row_t r;
		r = '{j0, j1, sw, hk, pr, cd, s0, s1, wc, e0, e1};
		rows.push_back(r);
	endtask

	task automatic wait_edges(input int n);
		int count;
		int guard;
		count = 0;
		guard = 0;
		while (count < n) begin
			@(posedge clk_sys);
			count++;
			guard++;
			if (guard > WAIT_LIMIT) begin
				$display("Wait for %0d clock edges exceeded its limit", n);
				$display("Result: FAILED");
				$fatal(1, "wait timeout");
			end
		end
	endtask

	task automatic check_pins(input int idx, input port_pins_t e0, input port_pins_t e1);
		port_pins_t exp [NUM_PLAYERS];
		exp[0] = e0;
		exp[1] = e1;
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			assert (port_pins[p] === exp[p]) else begin
				$display("MISMATCH at %0t ns: row %0d player %0d pins %b expected %b",
					$time, idx, p, port_pins[p], exp[p]);
				$display("Result: FAILED");
				$fatal(1, "pin check");
			end
		end
	endtask

	task automatic build_table();
		// Idle after reset with selects high and then each select alone
		add_row(20'h0, 20'h0, 0, 0, 0, 8'h0, SEL_NONE, SEL_NONE, 1, PINS_IDLE, PINS_IDLE);
		add_row(20'h0, 20'h0, 0, 0, 0, 8'h0, SEL_KP, SEL_KP, 1,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 0, 0, 8'h0, SEL_JOY, SEL_JOY, 1, PINS_IDLE, PINS_IDLE);
		// Up and fire1 on stick 0 with right on stick 1 before and after swap
		add_row(20'h00018, 20'h00001, 0, 0, 0, 8'h0, SEL_JOY, SEL_JOY, 1,
			5'b01110, 5'b11101);
		add_row(20'h00018, 20'h00001, 1, 0, 0, 8'h0, SEL_JOY, SEL_JOY, 1,
			5'b11101, 5'b01110);
		// Stick 0 holds digits 5 and 2 with blue and fire2 and stick 1 holds star and number
		add_row(20'h82420, 20'h000C0, 0, 0, 0, 8'h0, SEL_KP, SEL_KP, 1,
			{`CV_KEY_2, 1'b0}, {`CV_KEY_STAR, 1'b1});
		// Both halves selected with digit 1, left and fire1 on stick 0 and purple with down
		add_row(20'h00212, 20'h40004, 0, 0, 0, 8'h0, SEL_BOTH, SEL_BOTH, 1,
			5'b11000, 5'b00001);
		// Keyboard digit 7 from the top row and from the keypad
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_DIGIT7, SEL_KP, SEL_KP, 2,
			{`CV_KEY_7, 1'b1}, {`CV_KEY_7, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_DIGIT7, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_PAD7, SEL_KP, SEL_KP, 2,
			{`CV_KEY_7, 1'b1}, {`CV_KEY_7, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_PAD7, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		// Shift combinations for star and number
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_LSHIFT, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_DIGIT8, SEL_KP, SEL_KP, 2,
			{`CV_KEY_STAR, 1'b1}, {`CV_KEY_STAR, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_DIGIT8, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_DIGIT3, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NUMBER, 1'b1}, {`CV_KEY_NUMBER, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_DIGIT3, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_LSHIFT, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 1, `CV_SC_PAD_MINUS, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NUMBER, 1'b1}, {`CV_KEY_NUMBER, 1'b1});
		// Stick buttons merged with keypad minus where digit 9 beats number and number beats blue
		add_row(20'h20000, 20'h0, 0, 0, 0, 8'h0, SEL_KP, SEL_KP, 1,
			{`CV_KEY_9, 1'b1}, {`CV_KEY_NUMBER, 1'b1});
		add_row(20'h20000, 20'h80000, 0, 0, 0, 8'h0, SEL_KP, SEL_KP, 1,
			{`CV_KEY_9, 1'b1}, {`CV_KEY_NUMBER, 1'b1});
		add_row(20'h0, 20'h0, 0, 1, 0, `CV_SC_PAD_MINUS, SEL_KP, SEL_KP, 2,
			{`CV_KEY_NONE, 1'b1}, {`CV_KEY_NONE, 1'b1});
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(32'hba6c_376f));
		reset       = 1'b1;
		key_event   = '0;
		joy0        = '0;
		joy1        = '0;
		swap        = 1'b0;
		port_sel[0] = SEL_NONE;
		port_sel[1] = SEL_NONE;
		build_table();

		wait_edges(8);
		reset <= 1'b0;
		@(negedge clk_sys);
		check_pins(-1, PINS_IDLE, PINS_IDLE);

		foreach (rows[i]) begin
			@(posedge clk_sys);
			// Bits above the blue button are unused and carry noise
			joy0        <= {12'($urandom), rows[i].joy0};
			joy1        <= {12'($urandom), rows[i].joy1};
			swap        <= rows[i].swap;
			port_sel[0] <= rows[i].sel0;
			port_sel[1] <= rows[i].sel1;
			if (rows[i].has_key) begin
				key_event <= '{strobe: ~key_event.strobe, pressed: rows[i].pressed,
					extended: 1'b0, code: rows[i].code};
			end
			wait_edges(int'(rows[i].wait_cyc));
			@(negedge clk_sys);
			check_pins(i, rows[i].exp0, rows[i].exp1);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* source/cv_ctrl_top.sv */
// Controller port emulation top level
// Keyboard decoder, joystick mapper, keypad encoder and pin driver

`timescale 1ns/10ps
`default_nettype none

module cv_ctrl_top (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  cv_ctrl_pkg::key_event_t key_event_i,
	input  wire [31:0]              joy0_i,
	input  wire [31:0]              joy1_i,
	input  wire                     swap_i,
	input  cv_ctrl_pkg::port_sel_t  port_sel_i  [cv_ctrl_pkg::NUM_PLAYERS],
	output cv_ctrl_pkg::port_pins_t port_pins_o [cv_ctrl_pkg::NUM_PLAYERS]
);

	import cv_ctrl_pkg::*;

	cv_buttons_t kbd_buttons;
	cv_buttons_t player_buttons [NUM_PLAYERS];
	key_code_t   key_code       [NUM_PLAYERS];

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	kbd_keypad_decoder i_kbd_keypad_decoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.key_event_i   (key_event_i),
		.kbd_buttons_o (kbd_buttons)
	);

	joy_keypad_mapper i_joy_keypad_mapper (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.joy0_i           (joy0_i),
		.joy1_i           (joy1_i),
		.swap_i           (swap_i),
		.kbd_buttons_i    (kbd_buttons),
		.player_buttons_o (player_buttons)
	);

	////////////////////////////////////////
	// Encoding and pins
	////////////////////////////////////////

	keypad_encoder i_keypad_encoder (
		.player_buttons_i (player_buttons),
		.key_code_o       (key_code)
	);

	ctrl_port_driver i_ctrl_port_driver (
		.port_sel_i       (port_sel_i),
		.key_code_i       (key_code),
		.player_buttons_i (player_buttons),
		.port_pins_o      (port_pins_o)
	);

endmodule

`default_nettype wire

/* source/ctrl_port_driver.sv */
// Controller port pin driver
// Select-driven keypad and joystick halves, AND-combined per port

`timescale 1ns/10ps
`default_nettype none

module ctrl_port_driver (
	input  cv_ctrl_pkg::port_sel_t   port_sel_i       [cv_ctrl_pkg::NUM_PLAYERS],
	input  cv_ctrl_pkg::key_code_t   key_code_i       [cv_ctrl_pkg::NUM_PLAYERS],
	input  cv_ctrl_pkg::cv_buttons_t player_buttons_i [cv_ctrl_pkg::NUM_PLAYERS],
	output cv_ctrl_pkg::port_pins_t  port_pins_o      [cv_ctrl_pkg::NUM_PLAYERS]
);

	import cv_ctrl_pkg::*;

	port_pins_t keypad_half [NUM_PLAYERS];
	port_pins_t joy_half    [NUM_PLAYERS];

	always_comb begin
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			// P5 low selects keypad and right button
			if (!port_sel_i[p].keypad_sel_n) begin
				keypad_half[p].data_n = key_code_i[p];
				keypad_half[p].fire_n = ~player_buttons_i[p].fire2;
			end else begin
				keypad_half[p] = '1;
			end

			// P8 low selects stick and left button
			if (!port_sel_i[p].joy_sel_n) begin
				joy_half[p].data_n = ~{
					player_buttons_i[p].up,
					player_buttons_i[p].down,
					player_buttons_i[p].left,
					player_buttons_i[p].right
				};
				joy_half[p].fire_n = ~player_buttons_i[p].fire1;
			end else begin
				joy_half[p] = '1;
			end

			// Open-collector style merge of both halves
			port_pins_o[p] = keypad_half[p] & joy_half[p];
		end
	end

endmodule

`default_nettype wire

/* source/keypad_encoder.sv */
// Keypad priority encoder
// Fourteen keypad buttons per player to one console key code

`timescale 1ns/10ps
`default_nettype none

`include "cv_ctrl_cfg.svh"

module keypad_encoder (
	input  cv_ctrl_pkg::cv_buttons_t player_buttons_i [`CV_NUM_PLAYERS],
	output cv_ctrl_pkg::key_code_t   key_code_o       [`CV_NUM_PLAYERS]
);

	import cv_ctrl_pkg::*;

	// Index 0 has the highest priority
	localparam key_code_t KEY_TABLE [14] = '{
		`CV_KEY_0,
		`CV_KEY_1,
		`CV_KEY_2,
		`CV_KEY_3,
		`CV_KEY_4,
		`CV_KEY_5,
		`CV_KEY_6,
		`CV_KEY_7,
		`CV_KEY_8,
		`CV_KEY_9,
		`CV_KEY_STAR,
		`CV_KEY_NUMBER,
		`CV_KEY_PURPLE,
		`CV_KEY_BLUE
	};

	logic [13:0] keypad [`CV_NUM_PLAYERS];

	always_comb begin
		for (int p = 0; p < `CV_NUM_PLAYERS; p++) begin
			keypad[p] = {
				player_buttons_i[p].blue,
				player_buttons_i[p].purple,
				player_buttons_i[p].number,
				player_buttons_i[p].star,
				player_buttons_i[p].digit
			};
		end
	end

	////////////////////////////////////////
	// Priority search
	////////////////////////////////////////

	always_comb begin
		for (int p = 0; p < `CV_NUM_PLAYERS; p++) begin
			key_code_o[p] = `CV_KEY_NONE;
			// Walk down so the lowest pressed index is written last
			for (int k = 13; k >= 0; k--) begin
				if (keypad[p][k]) begin
					key_code_o[p] = KEY_TABLE[k];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/joy_keypad_mapper.sv */
// Joystick to keypad mapping
// Swap, bit mapping, keyboard merge, one register stage

`timescale 1ns/10ps
`default_nettype none

`include "cv_ctrl_cfg.svh"

module joy_keypad_mapper (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire [31:0]               joy0_i,
	input  wire [31:0]               joy1_i,
	input  wire                      swap_i,
	input  cv_ctrl_pkg::cv_buttons_t kbd_buttons_i,
	output cv_ctrl_pkg::cv_buttons_t player_buttons_o [`CV_NUM_PLAYERS]
);

	import cv_ctrl_pkg::*;

	logic [31:0] joy_word [`CV_NUM_PLAYERS];

	// Host joystick word to console button set
	function automatic cv_buttons_t map_joy(input logic [31:0] joy);
		cv_buttons_t b;
		b        = '0;
		b.digit  = joy[`CV_JOY_DIGIT0 +: 10];
		b.star   = joy[`CV_JOY_STAR];
		b.number = joy[`CV_JOY_NUMBER];
		b.purple = joy[`CV_JOY_PURPLE];
		b.blue   = joy[`CV_JOY_BLUE];
		b.up     = joy[`CV_JOY_UP];
		b.down   = joy[`CV_JOY_DOWN];
		b.left   = joy[`CV_JOY_LEFT];
		b.right  = joy[`CV_JOY_RIGHT];
		b.fire1  = joy[`CV_JOY_FIRE1];
		b.fire2  = joy[`CV_JOY_FIRE2];
		return b;
	endfunction

	// Swap exchanges the host sticks between the ports
	assign joy_word[0] = swap_i ? joy1_i : joy0_i;
	assign joy_word[1] = swap_i ? joy0_i : joy1_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int p = 0; p < `CV_NUM_PLAYERS; p++) begin
				player_buttons_o[p] <= '0;
			end
		end else begin
			for (int p = 0; p < `CV_NUM_PLAYERS; p++) begin
				player_buttons_o[p] <= map_joy(joy_word[p]) | kbd_buttons_i;
			end
		end
	end

endmodule

`default_nettype wire

/* source/kbd_keypad_decoder.sv */
// PS/2 keypad emulation
// Latches digit, star, minus and shift keys from the key event stream

`timescale 1ns/10ps
`default_nettype none

`include "cv_ctrl_cfg.svh"

module kbd_keypad_decoder (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  cv_ctrl_pkg::key_event_t  key_event_i,
	output cv_ctrl_pkg::cv_buttons_t kbd_buttons_o
);

	import cv_ctrl_pkg::*;

	logic       strobe_q;
	logic       event_stb;
	logic [9:0] digit_q;
	logic       star_q;
	logic       minus_q;
	logic       shift_q;

	// New event whenever the strobe changes level
	assign event_stb = key_event_i.strobe ^ strobe_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			strobe_q <= 1'b0;
			digit_q  <= '0;
			star_q   <= 1'b0;
			minus_q  <= 1'b0;
			shift_q  <= 1'b0;
		end else begin
			strobe_q <= key_event_i.strobe;
			if (event_stb) begin
				// Extended flag does not take part in the lookup
				case (key_event_i.code)
					`CV_SC_DIGIT0, `CV_SC_PAD0: digit_q[0] <= key_event_i.pressed;
					`CV_SC_DIGIT1, `CV_SC_PAD1: digit_q[1] <= key_event_i.pressed;
					`CV_SC_DIGIT2, `CV_SC_PAD2: digit_q[2] <= key_event_i.pressed;
					`CV_SC_DIGIT3, `CV_SC_PAD3: digit_q[3] <= key_event_i.pressed;
					`CV_SC_DIGIT4, `CV_SC_PAD4: digit_q[4] <= key_event_i.pressed;
					`CV_SC_DIGIT5, `CV_SC_PAD5: digit_q[5] <= key_event_i.pressed;
					`CV_SC_DIGIT6, `CV_SC_PAD6: digit_q[6] <= key_event_i.pressed;
					`CV_SC_DIGIT7, `CV_SC_PAD7: digit_q[7] <= key_event_i.pressed;
					`CV_SC_DIGIT8, `CV_SC_PAD8: digit_q[8] <= key_event_i.pressed;
					`CV_SC_DIGIT9, `CV_SC_PAD9: digit_q[9] <= key_event_i.pressed;
					`CV_SC_PAD_STAR:            star_q     <= key_event_i.pressed;
					`CV_SC_PAD_MINUS:           minus_q    <= key_event_i.pressed;
					// Either shift drives the same latch
					`CV_SC_LSHIFT, `CV_SC_RSHIFT: shift_q <= key_event_i.pressed;
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Button set seen by both players
	////////////////////////////////////////

	always_comb begin
		kbd_buttons_o = '0;
		kbd_buttons_o.digit = digit_q;
		// Shift turns 8 into star and 3 into number, so the digit
		// must not win the priority encoding
		kbd_buttons_o.digit[8] = digit_q[8] & ~shift_q;
		kbd_buttons_o.digit[3] = digit_q[3] & ~shift_q;
		kbd_buttons_o.star     = star_q | (shift_q & digit_q[8]);
		kbd_buttons_o.number   = minus_q | (shift_q & digit_q[3]);
	end

endmodule

`default_nettype wire

/* source/cv_ctrl_pkg.sv */
// Shared types of the controller port block
// Key events, button sets, port selects and port pins

`default_nettype none

`include "cv_ctrl_cfg.svh"

package cv_ctrl_pkg;

	localparam int NUM_PLAYERS = `CV_NUM_PLAYERS;

	////////////////////////////////////////
	// Keyboard side
	////////////////////////////////////////

	// Strobe toggles once for every key event
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	////////////////////////////////////////
	// Console side
	////////////////////////////////////////

	// Active high with digit[n] as the key for digit n
	typedef struct packed {
		logic [9:0] digit;
		logic       star;
		logic       number;
		logic       purple;
		logic       blue;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
		logic       fire1;
		logic       fire2;
	} cv_buttons_t;

	// 4-bit keypad code as read on P1..P4
	typedef logic [3:0] key_code_t;

	// Select lines driven by the console, active low
	typedef struct packed {
		logic keypad_sel_n;
		logic joy_sel_n;
	} port_sel_t;

	// Pins read by the console, active low
	// data_n[3] is P1, data_n[0] is P4
	typedef struct packed {
		logic [3:0] data_n;
		logic       fire_n;
	} port_pins_t;

endpackage

`default_nettype wire

/* include/cv_ctrl_cfg.svh */
// Controller port configuration macros
// Player count, joystick bit positions, PS/2 scan codes, console key codes

`ifndef CV_CTRL_CFG_SVH
`define CV_CTRL_CFG_SVH

`define CV_NUM_PLAYERS 2

// Host joystick word with digits 0 to 9 from CV_JOY_DIGIT0 upwards
`define CV_JOY_RIGHT   0
`define CV_JOY_LEFT    1
`define CV_JOY_DOWN    2
`define CV_JOY_UP      3
`define CV_JOY_FIRE1   4
`define CV_JOY_FIRE2   5
`define CV_JOY_STAR    6
`define CV_JOY_NUMBER  7
`define CV_JOY_DIGIT0  8
`define CV_JOY_PURPLE  18
`define CV_JOY_BLUE    19

// PS/2 set 2 scan codes of the top row digits
`define CV_SC_DIGIT0   8'h45
`define CV_SC_DIGIT1   8'h16
`define CV_SC_DIGIT2   8'h1E
`define CV_SC_DIGIT3   8'h26
`define CV_SC_DIGIT4   8'h25
`define CV_SC_DIGIT5   8'h2E
`define CV_SC_DIGIT6   8'h36
`define CV_SC_DIGIT7   8'h3D
`define CV_SC_DIGIT8   8'h3E
`define CV_SC_DIGIT9   8'h46

// Numeric keypad
`define CV_SC_PAD0     8'h70
`define CV_SC_PAD1     8'h69
`define CV_SC_PAD2     8'h72
`define CV_SC_PAD3     8'h7A
`define CV_SC_PAD4     8'h6B
`define CV_SC_PAD5     8'h73
`define CV_SC_PAD6     8'h74
`define CV_SC_PAD7     8'h6C
`define CV_SC_PAD8     8'h75
`define CV_SC_PAD9     8'h7D
`define CV_SC_PAD_STAR  8'h7C
`define CV_SC_PAD_MINUS 8'h7B
`define CV_SC_LSHIFT   8'h12
`define CV_SC_RSHIFT   8'h59

// Console keypad codes with bit 3 on P1 and bit 0 on P4
`define CV_KEY_0       4'b0011
`define CV_KEY_1       4'b1110
`define CV_KEY_2       4'b1101
`define CV_KEY_3       4'b0110
`define CV_KEY_4       4'b0001
`define CV_KEY_5       4'b1001
`define CV_KEY_6       4'b0111
`define CV_KEY_7       4'b1100
`define CV_KEY_8       4'b1000
`define CV_KEY_9       4'b1011
`define CV_KEY_STAR    4'b1010
`define CV_KEY_NUMBER  4'b0101
`define CV_KEY_PURPLE  4'b0100
`define CV_KEY_BLUE    4'b0010
`define CV_KEY_NONE    4'b1111

`endif
